/* filelist.f */
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_bus_if.sv
regfile.sv
instr_fetch.sv
decode_issue.sv
instr_exec.sv
instr_mem.sv
cpu_core.sv
cpu_top.sv
tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, then judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top -f filelist.f \
	&& ./obj_dir/Vtb_cpu_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "result: PASS" || { echo "result: FAIL"; exit 1; }

/* tb_cpu_top.sv */
`default_nettype none

module tb_cpu_top;
	import cpu_isa_pkg::*;

	localparam logic [31:0] SEED        = 32'h0f56fd9d;
	localparam int          IMEM_WORDS  = 512;
	localparam int          DMEM_WORDS  = 64;
	localparam int          PROG_WORDS  = 300;
	localparam int          NUM_COMMITS = 250;
	localparam int          MAX_CYCLES  = 20000;

	logic      clk = 1'b0;
	logic      rst;
	logic      ibus_read;
	uint32_t   ibus_address;
	uint32_t   ibus_rddata;
	logic      ibus_valid;
	logic      dbus_read;
	logic      dbus_write;
	uint32_t   dbus_address;
	uint32_t   dbus_wdata;
	uint32_t   dbus_rddata;
	logic      dbus_stall;
	logic      commit_valid;
	uint32_t   commit_pc;
	logic      commit_we;
	reg_addr_t commit_reg;
	uint32_t   commit_data;

	// bus side memories
	uint32_t imem [IMEM_WORDS];
	uint32_t dmem [DMEM_WORDS];

	// instruction-set model state
	uint32_t model_regs [REG_NUM];
	uint32_t model_mem [DMEM_WORDS];
	uint32_t model_pc;
	uint32_t model_npc;

	// register values as seen on the retire trace
	uint32_t trace_regs [REG_NUM];

	// accepted data bus writes, oldest first
	uint32_t wr_addr_q [$];
	uint32_t wr_data_q [$];

	int   errors      = 0;
	int   commits     = 0;
	int   loads       = 0;
	int   stores      = 0;
	logic retired_any = 1'b0;

	cpu_top dut(
		.clk,
		.rst,
		.ibus_read,
		.ibus_address,
		.ibus_rddata,
		.ibus_valid,
		.dbus_read,
		.dbus_write,
		.dbus_address,
		.dbus_wdata,
		.dbus_rddata,
		.dbus_stall,
		.commit_valid,
		.commit_pc,
		.commit_we,
		.commit_reg,
		.commit_data
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic build_program();
		int         i;
		int         kind;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [5:0] fn;
		logic       prev_branch;
		logic       prev_load;
		logic [4:0] load_reg;
		prev_branch = 1'b0;
		prev_load   = 1'b0;
		load_reg    = 5'd0;
		for (i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = '0;
		end
		// prologue gives every register a known value
		for (i = 1; i < REG_NUM; i++) begin
			imem[i - 1] = {OP_ADDIU, 5'd0, 5'(i), 16'($urandom())};
		end
		for (i = REG_NUM - 1; i < PROG_WORDS; i++) begin
			kind = $urandom_range(0, 9);
			// no branch in a delay slot
			if (prev_branch && kind == 9) begin
				kind = 0;
			end
			rs = 5'($urandom_range(0, 7));
			rt = 5'($urandom_range(0, 7));
			rd = 5'($urandom_range(0, 7));
			if (prev_load && $urandom_range(0, 1) == 1) begin
				rs = load_reg;
			end
			case (kind)
				0, 1, 2: begin
					case ($urandom_range(0, 5))
						0: fn = FN_ADDU;
						1: fn = FN_SUBU;
						2: fn = FN_AND;
						3: fn = FN_OR;
						4: fn = FN_XOR;
						default: fn = FN_SLT;
					endcase
					imem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
				end
				3: imem[i] = {OP_ADDIU, rs, rt, 16'($urandom())};
				4: imem[i] = {($urandom_range(0, 1) == 1 ? OP_ANDI : OP_ORI), rs, rt,
					16'($urandom())};
				5: imem[i] = {OP_LUI, 5'd0, rt, 16'($urandom())};
				// data accesses use r0 as base to stay inside dmem
				6, 7: imem[i] = {OP_LW, 5'd0, rt, 16'($urandom_range(0, 63) * 4)};
				8: imem[i] = {OP_SW, 5'd0, rt, 16'($urandom_range(0, 63) * 4)};
				default: imem[i] = {($urandom_range(0, 1) == 1 ? OP_BEQ : OP_BNE), rs, rt,
					16'($urandom_range(2, 8))};
			endcase
			prev_branch = kind == 9;
			prev_load   = kind == 6 || kind == 7;
			load_reg    = rt;
		end
	endtask

	task automatic drive_bus_responses();
		ibus_rddata = imem[ibus_address[10:2]];
		ibus_valid  = $urandom_range(0, 3) != 0;
		// only a read request gets the real word
		dbus_rddata = dbus_read ? dmem[dbus_address[7:2]] : ~dmem[dbus_address[7:2]];
		dbus_stall  = $urandom_range(0, 4) == 0;
	endtask

	// one architectural step, with delay slot
	task automatic retire_and_check();
		uint32_t    instr;
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] dst;
		logic       we;
		uint32_t    a;
		uint32_t    b;
		uint32_t    sext;
		uint32_t    zext;
		uint32_t    addr;
		uint32_t    val;
		uint32_t    next_pc;
		instr   = imem[model_pc[10:2]];
		op      = instr[31:26];
		rs      = instr[25:21];
		rt      = instr[20:16];
		rd      = instr[15:11];
		sext    = {{16{instr[15]}}, instr[15:0]};
		zext    = {16'd0, instr[15:0]};
		a       = model_regs[rs];
		b       = model_regs[rt];
		addr    = a + sext;
		dst     = 5'd0;
		val     = '0;
		next_pc = model_npc + 32'd4;
		case (op)
			OP_SPECIAL: begin
				dst = rd;
				case (instr[5:0])
					FN_ADDU: val = a + b;
					FN_SUBU: val = a - b;
					FN_AND:  val = a & b;
					FN_OR:   val = a | b;
					FN_XOR:  val = a ^ b;
					FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: dst = 5'd0;
				endcase
			end
			OP_ADDIU: begin
				dst = rt;
				val = a + sext;
			end
			OP_ANDI: begin
				dst = rt;
				val = a & zext;
			end
			OP_ORI: begin
				dst = rt;
				val = a | zext;
			end
			OP_LUI: begin
				dst = rt;
				val = {instr[15:0], 16'd0};
			end
			OP_LW: begin
				dst = rt;
				val = model_mem[addr[7:2]];
				loads++;
			end
			OP_SW: begin
				model_mem[addr[7:2]] = b;
				stores++;
				if (wr_addr_q.size() == 0) begin
					errors++;
					$display("store at pc %h retired without a data bus write", model_pc);
				end else begin
					check_value($sformatf("store address at pc %h", model_pc), addr,
						wr_addr_q.pop_front());
					check_value($sformatf("store data at pc %h", model_pc), b,
						wr_data_q.pop_front());
				end
			end
			OP_BEQ: begin
				if (a == b) begin
					next_pc = model_pc + 32'd4 + {sext[29:0], 2'b00};
				end
			end
			OP_BNE: begin
				if (a != b) begin
					next_pc = model_pc + 32'd4 + {sext[29:0], 2'b00};
				end
			end
			default: dst = 5'd0;
		endcase
		// r0 writes retire without a register write
		we = dst != 5'd0;
		check_value("commit_pc", model_pc, commit_pc);
		check_value($sformatf("commit_we at pc %h", model_pc), we, commit_we);
		if (we) begin
			check_value($sformatf("commit_reg at pc %h", model_pc), dst, commit_reg);
			check_value($sformatf("commit_data at pc %h", model_pc), val, commit_data);
			model_regs[dst] = val;
		end
		model_pc  = model_npc;
		model_npc = next_pc;
	endtask

	task automatic sample_cycle();
		if (!retired_any) begin
			check_value("dbus_read before first retire", 1'b0, dbus_read);
			check_value("dbus_write before first retire", 1'b0, dbus_write);
		end
		if (dbus_stall) begin
			check_value("commit_valid under dbus stall", 1'b0, commit_valid);
			check_value("ibus_read under dbus stall", 1'b0, ibus_read);
		end
		if (dbus_write && !dbus_stall) begin
			dmem[dbus_address[7:2]] = dbus_wdata;
			wr_addr_q.push_back(dbus_address);
			wr_data_q.push_back(dbus_wdata);
		end
		if (commit_valid) begin
			if (!retired_any) begin
				check_value("first commit_pc", RESET_PC, commit_pc);
			end
			retired_any = 1'b1;
			if (commit_we && commit_reg == 5'd0) begin
				errors++;
				$display("register zero written by the retire at pc %h", commit_pc);
			end else if (commit_we) begin
				trace_regs[commit_reg] = commit_data;
			end
			retire_and_check();
			commits++;
		end
	endtask

	task automatic compare_final_registers();
		int r;
		for (r = 1; r < REG_NUM; r++) begin
			check_value($sformatf("final r%0d", r), model_regs[r], trace_regs[r]);
		end
	endtask

	initial begin
		int i;
		int cycles;
		void'($urandom(SEED));
		rst         = 1'b1;
		ibus_rddata = '0;
		ibus_valid  = 1'b0;
		dbus_rddata = '0;
		dbus_stall  = 1'b0;
		for (i = 0; i < DMEM_WORDS; i++) begin
			dmem[i]      = $urandom();
			model_mem[i] = dmem[i];
		end
		for (i = 0; i < REG_NUM; i++) begin
			model_regs[i] = '0;
			trace_regs[i] = '0;
		end
		model_pc  = RESET_PC;
		model_npc = RESET_PC + 32'd4;
		build_program();

		repeat (3) @(posedge clk);
		@(negedge clk);
		check_value("ibus_read in reset", 1'b0, ibus_read);
		check_value("commit_valid in reset", 1'b0, commit_valid);
		check_value("dbus_read in reset", 1'b0, dbus_read);
		check_value("dbus_write in reset", 1'b0, dbus_write);
		rst = 1'b0;

		cycles = 0;
		while (commits < NUM_COMMITS && cycles < MAX_CYCLES) begin
			@(negedge clk);
			drive_bus_responses();
			#1;
			sample_cycle();
			cycles++;
		end

		if (commits < NUM_COMMITS) begin
			errors++;
			$display("timeout after %0d cycles, %0d of %0d instructions retired",
				cycles, commits, NUM_COMMITS);
		end else begin
			compare_final_registers();
		end

		$display("commits %0d, loads %0d, stores %0d, errors %0d",
			commits, loads, stores, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* cpu_top.sv */
`default_nettype none

module cpu_top(
	input  logic                   clk,
	input  logic                   rst,
	output logic                   ibus_read,
	output cpu_isa_pkg::uint32_t   ibus_address,
	input  cpu_isa_pkg::uint32_t   ibus_rddata,
	input  logic                   ibus_valid,
	output logic                   dbus_read,
	output logic                   dbus_write,
	output cpu_isa_pkg::uint32_t   dbus_address,
	output cpu_isa_pkg::uint32_t   dbus_wdata,
	input  cpu_isa_pkg::uint32_t   dbus_rddata,
	input  logic                   dbus_stall,
	output logic                   commit_valid,
	output cpu_isa_pkg::uint32_t   commit_pc,
	output logic                   commit_we,
	output cpu_isa_pkg::reg_addr_t commit_reg,
	output cpu_isa_pkg::uint32_t   commit_data
);
	cpu_ibus_if ibus();
	cpu_dbus_if dbus();

	assign ibus_read    = ibus.read;
	assign ibus_address = ibus.address;
	assign ibus.rddata  = ibus_rddata;
	assign ibus.valid   = ibus_valid;

	assign dbus_read    = dbus.read;
	assign dbus_write   = dbus.write;
	assign dbus_address = dbus.address;
	assign dbus_wdata   = dbus.wdata;
	assign dbus.rddata  = dbus_rddata;
	assign dbus.stall   = dbus_stall;

	cpu_core cpu_core_inst(
		.clk,
		.rst,
		.ibus,
		.dbus,
		.commit_valid,
		.commit_pc,
		.commit_we,
		.commit_reg,
		.commit_data
	);

endmodule

`default_nettype wire

/* cpu_core.sv */
`default_nettype none

module cpu_core(
	input  logic                   clk,
	input  logic                   rst,
	cpu_ibus_if.master             ibus,
	cpu_dbus_if.master             dbus,
	output logic                   commit_valid,
	output cpu_isa_pkg::uint32_t   commit_pc,
	output logic                   commit_we,
	output cpu_isa_pkg::reg_addr_t commit_reg,
	output cpu_isa_pkg::uint32_t   commit_data
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	fetch_entry_t     fetch_entry;
	pipeline_decode_t pipeline_decode;
	pipeline_exec_t   pipeline_exec;
	pipeline_memwb_t  pipeline_wb;
	branch_resolved_t resolved_branch;

	reg_addr_t [1:0] reg_raddr;
	uint32_t   [1:0] reg_rdata;
	logic            reg_we;

	logic stall_from_id;
	logic stall_from_mm;
	logic stall_if;
	logic stall_id;
	logic stall_ex;
	logic flush_if;

	// mem stall freezes all stages, load-use holds fetch and decode
	assign stall_ex = stall_from_mm;
	assign stall_id = stall_from_mm;
	assign stall_if = stall_from_mm || stall_from_id;
	assign flush_if = resolved_branch.valid;

	regfile regfile_inst(
		.clk,
		.rst,
		.raddr ( reg_raddr         ),
		.rdata ( reg_rdata         ),
		.we    ( reg_we            ),
		.waddr ( pipeline_wb.rd    ),
		.wdata ( pipeline_wb.wdata )
	);

	instr_fetch instr_fetch_inst(
		.clk,
		.rst,
		.stall           ( stall_if        ),
		.flush           ( flush_if        ),
		.resolved_branch ( resolved_branch ),
		.ibus,
		.fetch_entry     ( fetch_entry     )
	);

	decode_issue decode_issue_inst(
		.clk,
		.rst,
		.fetch_entry,
		.stall           ( stall_id        ),
		.pipeline_exec,
		.pipeline_wb,
		.reg_raddr,
		.reg_rdata,
		.pipeline_decode,
		.stall_req       ( stall_from_id   )
	);

	instr_exec instr_exec_inst(
		.clk,
		.rst,
		.stall           ( stall_ex        ),
		.data            ( pipeline_decode ),
		.resolved_branch ( resolved_branch ),
		.result          ( pipeline_exec   )
	);

	instr_mem instr_mem_inst(
		.clk,
		.rst,
		.data      ( pipeline_exec ),
		.dbus,
		.result    ( pipeline_wb   ),
		.stall_req ( stall_from_mm )
	);

	// MEM/WB is held under stall, so it retires once the stall drops
	assign reg_we       = pipeline_wb.valid && pipeline_wb.written && !stall_from_mm;
	assign commit_valid = pipeline_wb.valid && !stall_from_mm;
	assign commit_pc    = pipeline_wb.pc;
	assign commit_we    = reg_we;
	assign commit_reg   = pipeline_wb.rd;
	assign commit_data  = pipeline_wb.wdata;

endmodule

`default_nettype wire

/* instr_mem.sv */
`default_nettype none

module instr_mem(
	input  logic                          clk,
	input  logic                          rst,
	input  cpu_pipe_pkg::pipeline_exec_t  data,
	cpu_dbus_if.master                    dbus,
	output cpu_pipe_pkg::pipeline_memwb_t result,
	output logic                          stall_req
);
	import cpu_pipe_pkg::*;

	pipeline_memwb_t mem_next;

	// request held steady by the frozen EX/MEM register
	assign dbus.read    = data.valid && data.is_load;
	assign dbus.write   = data.valid && data.is_store;
	assign dbus.address = data.result;
	assign dbus.wdata   = data.store_data;
	assign stall_req    = dbus.stall;

	always_comb begin
		mem_next.valid   = data.valid;
		mem_next.pc      = data.pc;
		mem_next.rd      = data.rd;
		mem_next.written = data.written;
		mem_next.wdata   = data.is_load ? dbus.rddata : data.result;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
		end else if (!stall_req) begin
			result <= mem_next;
		end
	end

	a_no_read_and_write: assert property (@(posedge clk) disable iff (rst)
		!(dbus.read && dbus.write));

endmodule

`default_nettype wire

/* instr_exec.sv */
`default_nettype none

module instr_exec(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           stall,
	input  cpu_pipe_pkg::pipeline_decode_t data,
	output cpu_pipe_pkg::branch_resolved_t resolved_branch,
	output cpu_pipe_pkg::pipeline_exec_t   result
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	uint32_t        alu_out;
	logic           operands_equal;
	pipeline_exec_t ex_next;

	always_comb begin
		unique case (data.alu_op)
			ALU_ADD: alu_out = data.op1 + data.op2;
			ALU_SUB: alu_out = data.op1 - data.op2;
			ALU_AND: alu_out = data.op1 & data.op2;
			ALU_OR:  alu_out = data.op1 | data.op2;
			ALU_XOR: alu_out = data.op1 ^ data.op2;
			ALU_SLT: alu_out = {31'b0, $signed(data.op1) < $signed(data.op2)};
			ALU_LUI: alu_out = {data.op2[15:0], 16'b0};
			default: alu_out = '0;
		endcase
	end

	assign operands_equal = data.op1 == data.op2;

	// delay slot is already in decode, only fetch gets redirected
	always_comb begin
		resolved_branch.valid  = data.valid && data.is_branch
			&& (operands_equal != data.branch_ne);
		resolved_branch.target = data.branch_target;
	end

	always_comb begin
		ex_next.valid      = data.valid;
		ex_next.pc         = data.pc;
		ex_next.rd         = data.rd;
		ex_next.written    = data.written;
		ex_next.result     = alu_out;
		ex_next.is_load    = data.is_load;
		ex_next.is_store   = data.is_store;
		ex_next.store_data = data.is_store ? data.store_data : '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
		end else if (!stall) begin
			result <= ex_next;
		end
	end

endmodule

`default_nettype wire

/* decode_issue.sv */
`default_nettype none

module decode_issue(
	input  logic                           clk,
	input  logic                           rst,
	input  cpu_pipe_pkg::fetch_entry_t     fetch_entry,
	input  logic                           stall,
	input  cpu_pipe_pkg::pipeline_exec_t   pipeline_exec,
	input  cpu_pipe_pkg::pipeline_memwb_t  pipeline_wb,
	output cpu_isa_pkg::reg_addr_t [1:0]   reg_raddr,
	input  cpu_isa_pkg::uint32_t   [1:0]   reg_rdata,
	output cpu_pipe_pkg::pipeline_decode_t pipeline_decode,
	output logic                           stall_req
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	instr_fields_t    fields;
	funct_t           funct;
	uint32_t          imm_sext;
	uint32_t          imm_zext;
	logic             zext;
	logic             uses_rs;
	logic             uses_rt;
	reg_addr_t        dest;
	pipeline_decode_t dec;
	pipeline_decode_t id_ex_q;
	reg_addr_t        rs_q;
	reg_addr_t        rt_q;

	function automatic uint32_t forward(reg_addr_t r, uint32_t v,
			pipeline_exec_t ex, pipeline_memwb_t wb);
		if (ex.valid && ex.written && ex.rd == r) begin
			return ex.result;
		end else if (wb.valid && wb.written && wb.rd == r) begin
			return wb.wdata;
		end
		return v;
	endfunction

	assign fields       = instr_fields_t'(fetch_entry.instr);
	assign funct        = funct_t'(fields.imm[5:0]);
	assign imm_sext     = {{16{fields.imm[15]}}, fields.imm};
	assign imm_zext     = {16'b0, fields.imm};
	assign reg_raddr[0] = fields.rs;
	assign reg_raddr[1] = fields.rt;

	always_comb begin
		dec     = '0;
		zext    = 1'b0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		dest    = '0;
		if (fetch_entry.valid) begin
			unique case (fields.opcode)
				OP_SPECIAL: begin
					uses_rs = 1'b1;
					uses_rt = 1'b1;
					dest    = fields.imm[15:11];
					unique case (funct)
						FN_ADDU: dec.alu_op = ALU_ADD;
						FN_SUBU: dec.alu_op = ALU_SUB;
						FN_AND:  dec.alu_op = ALU_AND;
						FN_OR:   dec.alu_op = ALU_OR;
						FN_XOR:  dec.alu_op = ALU_XOR;
						FN_SLT:  dec.alu_op = ALU_SLT;
						default: begin
							// retires as a nop
							uses_rs = 1'b0;
							uses_rt = 1'b0;
							dest    = '0;
						end
					endcase
				end
				OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
					uses_rs     = fields.opcode != OP_LUI;
					dest        = fields.rt;
					dec.imm_sel = 1'b1;
					zext        = fields.opcode inside {OP_ANDI, OP_ORI, OP_LUI};
					dec.is_load = fields.opcode == OP_LW;
					dec.alu_op  = fields.opcode == OP_ANDI ? ALU_AND
						: fields.opcode == OP_ORI ? ALU_OR
						: fields.opcode == OP_LUI ? ALU_LUI : ALU_ADD;
				end
				OP_SW: begin
					uses_rs      = 1'b1;
					uses_rt      = 1'b1;
					dec.imm_sel  = 1'b1;
					dec.is_store = 1'b1;
				end
				OP_BEQ, OP_BNE: begin
					uses_rs       = 1'b1;
					uses_rt       = 1'b1;
					dec.is_branch = 1'b1;
					dec.branch_ne = fields.opcode == OP_BNE;
				end
				default: dest = '0;
			endcase
		end
		dec.valid         = fetch_entry.valid;
		dec.pc            = fetch_entry.pc;
		dec.branch_target = fetch_entry.pc + 32'd4 + {imm_sext[29:0], 2'b00};
		dec.rd            = dest;
		dec.written       = dest != '0;
		dec.op1           = reg_rdata[0];
		dec.op2           = !dec.imm_sel ? reg_rdata[1] : zext ? imm_zext : imm_sext;
		dec.store_data    = reg_rdata[1];
	end

	// load result is not ready for the very next instruction
	assign stall_req = id_ex_q.valid && id_ex_q.is_load && id_ex_q.written
		&& ((uses_rs && fields.rs == id_ex_q.rd) || (uses_rt && fields.rt == id_ex_q.rd));

	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex_q <= '0;
		end else if (!stall) begin
			id_ex_q <= stall_req ? '0 : dec;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			rs_q <= fields.rs;
			rt_q <= fields.rt;
		end
	end

	// operands patched from EX/MEM first, then MEM/WB
	always_comb begin
		pipeline_decode     = id_ex_q;
		pipeline_decode.op1 = forward(rs_q, id_ex_q.op1, pipeline_exec, pipeline_wb);
		if (!id_ex_q.imm_sel) begin
			pipeline_decode.op2 = forward(rt_q, id_ex_q.op2, pipeline_exec, pipeline_wb);
		end
		pipeline_decode.store_data =
			forward(rt_q, id_ex_q.store_data, pipeline_exec, pipeline_wb);
	end

	a_stall_needs_entry: assert property (@(posedge clk) disable iff (rst)
		stall_req |-> fetch_entry.valid);

endmodule

`default_nettype wire

/* instr_fetch.sv */
`default_nettype none

module instr_fetch(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           stall,
	input  logic                           flush,
	input  cpu_pipe_pkg::branch_resolved_t resolved_branch,
	cpu_ibus_if.master                     ibus,
	output cpu_pipe_pkg::fetch_entry_t     fetch_entry
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	uint32_t pc;
	logic    running;
	logic    accept;
	logic    redirect_pending;
	uint32_t pending_target;
	uint32_t target;
	logic    delay_slot_held;

	assign ibus.read    = running && !stall;
	assign ibus.address = pc;
	assign accept       = ibus.read && ibus.valid;
	assign target       = resolved_branch.valid ? resolved_branch.target : pending_target;

	// delay slot already in IF/ID means the word on the bus now is past it
	assign delay_slot_held = flush && fetch_entry.valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc               <= RESET_PC;
			running          <= 1'b0;
			redirect_pending <= 1'b0;
			fetch_entry      <= '0;
		end else begin
			running <= 1'b1;
			if (!stall) begin
				if (delay_slot_held) begin
					fetch_entry.valid <= 1'b0;
					pc                <= target;
					redirect_pending  <= 1'b0;
				end else if (accept) begin
					fetch_entry.valid <= 1'b1;
					fetch_entry.pc    <= pc;
					fetch_entry.instr <= ibus.rddata;
					pc                <= (flush || redirect_pending) ? target : pc + 32'd4;
					redirect_pending  <= 1'b0;
				end else begin
					// bus wait, pc stays
					fetch_entry.valid <= 1'b0;
					if (flush) begin
						redirect_pending <= 1'b1;
					end
				end
			end
		end
	end

	// branch seen before its delay slot arrived
	always_ff @(posedge clk) begin
		if (!stall && flush) begin
			pending_target <= resolved_branch.target;
		end
	end

endmodule

`default_nettype wire

/* regfile.sv */
`default_nettype none

module regfile(
	input  logic                         clk,
	input  logic                         rst,
	input  cpu_isa_pkg::reg_addr_t [1:0] raddr,
	output cpu_isa_pkg::uint32_t   [1:0] rdata,
	input  logic                         we,
	input  cpu_isa_pkg::reg_addr_t       waddr,
	input  cpu_isa_pkg::uint32_t         wdata
);
	import cpu_isa_pkg::*;

	uint32_t regs [REG_NUM];

	always_ff @(posedge clk) begin
		if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// same-cycle write is visible to the reader
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			if (raddr[i] == '0) begin
				rdata[i] = '0;
			end else if (we && waddr == raddr[i]) begin
				rdata[i] = wdata;
			end else begin
				rdata[i] = regs[raddr[i]];
			end
		end
	end

	a_r0_stays_zero: assert property (@(posedge clk) disable iff (rst)
		(we && waddr == '0) |=> (raddr[0] != '0 || rdata[0] == '0)
			&& (raddr[1] != '0 || rdata[1] == '0));

endmodule

`default_nettype wire

/* cpu_bus_if.sv */
`default_nettype none

interface cpu_ibus_if;
	import cpu_isa_pkg::*;

	logic    read;
	uint32_t address;
	uint32_t rddata;
	logic    valid;

	modport master(output read, address, input rddata, valid);
	modport slave(input read, address, output rddata, valid);
endinterface

interface cpu_dbus_if;
	import cpu_isa_pkg::*;

	logic    read;
	logic    write;
	uint32_t address;
	uint32_t wdata;
	uint32_t rddata;
	logic    stall;

	modport master(output read, write, address, wdata, input rddata, stall);
	modport slave(input read, write, address, wdata, output rddata, stall);
endinterface

`default_nettype wire

/* cpu_pipe_pkg.sv */
`default_nettype none

package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	typedef struct packed {
		logic    valid;
		uint32_t pc;
		uint32_t instr;
	} fetch_entry_t;

	typedef struct packed {
		logic      valid;
		uint32_t   pc;
		alu_op_t   alu_op;
		uint32_t   op1;
		uint32_t   op2;
		logic      imm_sel;
		reg_addr_t rd;
		logic      written;
		logic      is_load;
		logic      is_store;
		logic      is_branch;
		logic      branch_ne;
		uint32_t   branch_target;
		uint32_t   store_data;
	} pipeline_decode_t;

	typedef struct packed {
		logic      valid;
		uint32_t   pc;
		reg_addr_t rd;
		logic      written;
		uint32_t   result;
		logic      is_load;
		logic      is_store;
		uint32_t   store_data;
	} pipeline_exec_t;

	typedef struct packed {
		logic      valid;
		uint32_t   pc;
		reg_addr_t rd;
		logic      written;
		uint32_t   wdata;
	} pipeline_memwb_t;

	typedef struct packed {
		logic    valid;
		uint32_t target;
	} branch_resolved_t;

endpackage

`default_nettype wire

/* cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	localparam int      REG_NUM  = 32;
	localparam uint32_t RESET_PC = 32'h0000_0000;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	// i-type view of a word; rd and funct live inside imm for r-type
	typedef struct packed {
		opcode_t     opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} instr_fields_t;

endpackage

`default_nettype wire
